// File: dv/execGolden.txt
# Header: memory base word, line count. Word i = base ^ (i * 0405)
# Lines: type op dst issue src1 src2 latency delay exp1 exp2 chain (exp load: data addr, store: addr data)
5A00 16
0 0 01 1 0012 0034 0 2 0046 0000 0
0 1 02 2 0010 0020 0 2 FFF0 0000 0
0 2 03 3 F0F0 3C3C 0 2 3030 0000 0
0 3 04 4 F000 000F 0 2 F00F 0000 0
0 4 05 5 AAAA FFFF 0 2 5555 0000 0
0 5 06 6 0123 0004 0 2 1230 0000 0
0 6 07 7 0123 0456 0 2 EDC2 0000 0
1 0 08 8 0003 0000 3 5 560F 0003 0
1 1 00 9 000A BEEF 0 1 000A BEEF 0
1 0 09 A 000A 0000 1 3 BEEF 000A 0
1 0 0A B F021 0000 5 7 DEA5 0021 0
1 0 0B C 0003 0000 1 3 560F 0003 1
0 0 0C D 0001 0001 0 3 0002 0000 0
1 1 00 E 0005 1234 0 1 0005 1234 0
1 0 0D F 0005 0000 1 3 1234 0005 1
0 6 0E 0 0003 0005 0 3 000F 0000 0

// File: vlog.f
src/execPkg.sv
src/execResultIf.sv
src/aluUnit.sv
src/ldStUnit.sv
src/wbArbiter.sv
src/execUnit.sv
dv/execUnitTb.sv

// File: run.sh
#!/bin/bash
# Build and run the execution stage testbench with Verilator
verilator --binary --timing --assert -f vlog.f --top-module execUnitTb -o execSim \
	&& ./obj_dir/execSim | grep "No errors" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// File: dv/execUnitTb.sv
/*
	Execution stage testbench
	Replays golden commands, models the memory, checks every
	write-back, memory access and busy level, then adds random ALU traffic
*/

`timescale 1ns/1ps

module execUnitTb;

	logic				clock;
	logic				rstN;
	logic				cmdValid;
	execPkg::opTypeT	cmdType;
	logic [2:0]			cmdOp;
	execPkg::regIdxT	cmdDst;
	execPkg::issueNoT	cmdIssueNo;
	execPkg::dataT		cmdSrc1;
	execPkg::dataT		cmdSrc2;
	execPkg::issueNoT	curIssueNo;
	logic				memReq;
	logic				memWe;
	execPkg::addrT		memAddr;
	execPkg::dataT		memWData;
	logic				ldValid;
	execPkg::dataT		ldData;
	logic				lsBusy;
	logic				wbValid;
	execPkg::regIdxT	wbDst;
	execPkg::issueNoT	wbIssueNo;
	execPkg::dataT		wbData;
	logic				storeDone;

	execPkg::dataT		mem [64];			// Memory model
	execPkg::regIdxT	expDst [16];		// Scoreboard by issue number
	execPkg::dataT		expData [16];
	int					expCycle [16];
	logic				expIsLoad [16];
	execPkg::issueNoT	orderQ [$];			// Write-backs still due
	int					cycleCount = 0;
	int					cycleLimit = 1000;
	int					memCycle = -1;		// Cycle of the expected request
	execPkg::addrT		memAddrExp;
	execPkg::dataT		memDataExp;
	logic				memWeExp;
	logic				busyExpect = 1'b0;
	int					curLat = 0;
	int					ldCount = 0;
	execPkg::addrT		ldAddr;
	int					seed;

	execUnit #(.DataWidth(16)) i_execUnit (.*);

	always #2 clock = ~clock;

	task automatic failRun();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input execPkg::dataT got,
			input execPkg::dataT exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkReg(input string name, input execPkg::regIdxT got,
			input execPkg::regIdxT exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkIssue(input string name, input execPkg::issueNoT got,
			input execPkg::issueNoT exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkAddr(input string name, input execPkg::addrT got,
			input execPkg::addrT exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %b expected %b", $time, name, got, exp);
			failRun();
		end
	endtask

	// Expected ALU result for one opcode
	function automatic execPkg::dataT aluModel(input int op, input execPkg::dataT a,
			input execPkg::dataT b);
		case (op)
			0:			return a + b;
			1:			return a - b;
			2:			return a & b;
			3:			return a | b;
			4:			return a ^ b;
			5:			return a << b[3:0];
			6:			return 16'(a * b);		// Low half of the product
			default:	return 16'h0;
		endcase
	endfunction

	// Post the expectations of one command and drive it
	task automatic sendCmd(input int t, input int op, input int dst, input int iss,
			input int s1, input int s2, input int lat, input int delay,
			input int e1, input int e2);
		execPkg::issueNoT i;
		i = 4'(iss);
		if (t == 0 || op[0] == 1'b0) begin
			expDst[i]		= 5'(dst);
			expData[i]		= 16'(e1);
			expCycle[i]		= cycleCount + delay;
			expIsLoad[i]	= (t != 0);
			orderQ.push_back(i);
		end
		if (t != 0) begin
			memCycle	= cycleCount + 1;
			memWeExp	= op[0];
			memAddrExp	= op[0] ? 12'(e1) : 12'(e2);
			memDataExp	= 16'(e2);
			curLat		= lat;
		end
		cmdValid	= 1'b1;
		cmdType		= execPkg::opTypeT'(t[0]);
		cmdOp		= 3'(op);
		cmdDst		= 5'(dst);
		cmdIssueNo	= i;
		cmdSrc1		= 16'(s1);
		cmdSrc2		= 16'(s2);
		curIssueNo	= i + 4'd1;
	endtask

	//////////////////////////////
	// Memory model
	//////////////////////////////
	always @(negedge clock) begin
		if (rstN && memReq) begin
			if (memWe) begin
				mem[memAddr[5:0]] = memWData;
			end else begin
				ldCount	= curLat;
				ldAddr	= memAddr;
			end
		end
	end

	always @(posedge clock) begin
		#1;
		ldValid = 1'b0;
		if (ldCount > 0) begin
			ldCount--;
			if (ldCount == 0) begin
				ldValid	= 1'b1;
				ldData	= mem[ldAddr[5:0]];
			end
		end
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			failRun();
		end
	end

	//////////////////////////////
	// Monitor and scoreboard
	//////////////////////////////
	always @(negedge clock) begin
		execPkg::issueNoT e;
		if (rstN) begin
			if (cycleCount == memCycle) begin
				checkBit("memReq", memReq, 1'b1);
				checkBit("memWe", memWe, memWeExp);
				checkBit("storeDone", storeDone, memWeExp);
				checkAddr("memAddr", memAddr, memAddrExp);
				if (memWeExp) begin
					checkData("memWData", memWData, memDataExp);
				end else begin
					busyExpect = 1'b1;				// Load now outstanding
				end
			end else if (memReq || storeDone) begin
				$display("Memory request or store completion without a command");
				failRun();
			end
			checkBit("lsBusy", lsBusy, busyExpect);
			if (wbValid) begin
				if (orderQ.size() == 0) begin
					$display("Write-back seen while no result was due");
					failRun();
				end
				e = orderQ.pop_front();
				checkIssue("wbIssueNo", wbIssueNo, e);
				checkReg("wbDst", wbDst, expDst[e]);
				checkData("wbData", wbData, expData[e]);
				if (cycleCount != expCycle[e]) begin
					$display("Write-back of issue %0d came in the wrong cycle", e);
					failRun();
				end
				if (expIsLoad[e]) begin
					busyExpect = 1'b0;
				end
			end
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		int fd, n, numLines, memBase;
		int gType, gOp, gDst, gIssue, gSrc1, gSrc2, gLat, gDelay, gExp1, gExp2, gChain;
		int nextIssue;
		string comment;
		clock = 1'b0;
		rstN = 1'b0;
		cmdValid = 1'b0;
		cmdType = execPkg::opAlu;
		cmdOp = 3'd0;
		cmdDst = 5'd0;
		cmdIssueNo = 4'd0;
		cmdSrc1 = 16'h0;
		cmdSrc2 = 16'h0;
		curIssueNo = 4'd0;
		ldValid = 1'b0;
		ldData = 16'h0;
		seed = 32'h14ca;
		fd = $fopen("dv/execGolden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the golden file");
			failRun();
		end
		n = $fgets(comment, fd);
		n = $fgets(comment, fd);
		n = $fscanf(fd, "%h %d\n", memBase, numLines);
		cycleLimit = 20 * numLines + 200;
		for (int i = 0; i < 64; i++) begin
			mem[i] = 16'(memBase) ^ (16'(i) * 16'h0405);	// Every address bit counts
		end
		repeat (3) @(posedge clock);
		#1 rstN = 1'b1;
		repeat (2) @(posedge clock);	// Idle outputs checked by the monitor
		for (int l = 0; l < numLines; l++) begin
			n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h\n", gType, gOp, gDst, gIssue,
				gSrc1, gSrc2, gLat, gDelay, gExp1, gExp2, gChain);
			if (n != 11) begin
				$display("Golden line %0d is malformed", l);
				failRun();
			end
			@(posedge clock);
			#1;
			sendCmd(gType, gOp, gDst, gIssue, gSrc1, gSrc2, gLat, gDelay, gExp1, gExp2);
			if (gChain == 0) begin
				@(posedge clock);
				#1 cmdValid = 1'b0;
				while (orderQ.size() != 0 || busyExpect || cycleCount <= memCycle) begin
					@(posedge clock);
				end
			end
		end
		$fclose(fd);
		nextIssue = 1;
		for (int k = 0; k < 8; k++) begin
			gOp = int'($unsigned($random(seed)) % 7);
			gSrc1 = int'(16'($random(seed)));
			gSrc2 = int'(16'($random(seed)));
			@(posedge clock);
			#1;
			sendCmd(0, gOp, k + 16, nextIssue, gSrc1, gSrc2, 0, 2,
				int'(aluModel(gOp, 16'(gSrc1), 16'(gSrc2))), 0);
			nextIssue++;
			@(posedge clock);
			#1 cmdValid = 1'b0;
			while (orderQ.size() != 0) begin
				@(posedge clock);
			end
		end
		repeat (3) @(posedge clock);
		$display("No errors");
		$finish;
	end

endmodule

// File: src/execUnit.sv
/*
	Scalar execution stage
	Steers each command to the ALU or the load/store unit and
	merges both results onto one write-back port
*/

`timescale 1ns/1ps

module execUnit #(
	parameter int DataWidth = execPkg::DataW
)(
	input	logic				clock,
	input	logic				rstN,
	input	logic				cmdValid,			// Command strobe
	input	execPkg::opTypeT	cmdType,
	input	logic [execPkg::OpW-1:0]	cmdOp,
	input	execPkg::regIdxT	cmdDst,
	input	execPkg::issueNoT	cmdIssueNo,
	input	execPkg::dataT		cmdSrc1,
	input	execPkg::dataT		cmdSrc2,
	input	execPkg::issueNoT	curIssueNo,
	output	logic				memReq,
	output	logic				memWe,
	output	execPkg::addrT		memAddr,
	output	execPkg::dataT		memWData,
	input	logic				ldValid,
	input	execPkg::dataT		ldData,
	output	logic				lsBusy,
	output	logic				wbValid,
	output	execPkg::regIdxT	wbDst,
	output	execPkg::issueNoT	wbIssueNo,
	output	execPkg::dataT		wbData,
	output	logic				storeDone
);

	logic						aluStart;
	logic						lsStart;

	execResultIf				aluRes ();
	execResultIf				lsRes ();

	assign aluStart		= cmdValid & (cmdType == execPkg::opAlu);
	assign lsStart		= cmdValid & (cmdType == execPkg::opLdSt);

	aluUnit #(
		.DataWidth(		DataWidth						)
	) i_aluUnit (
		.clock(			clock							),
		.rstN(			rstN							),
		.start(			aluStart						),
		.op(			execPkg::aluOpT'(cmdOp)			),
		.dst(			cmdDst							),
		.issueNo(		cmdIssueNo						),
		.src1(			cmdSrc1							),
		.src2(			cmdSrc2							),
		.res(			aluRes.unit						)
	);

	ldStUnit i_ldStUnit (
		.clock(			clock							),
		.rstN(			rstN							),
		.start(			lsStart							),
		.isStore(		cmdOp[0]						),	// Odd opcode stores
		.dst(			cmdDst							),
		.issueNo(		cmdIssueNo						),
		.addr(			cmdSrc1[execPkg::AddrW-1:0]		),	// Truncated word address
		.stData(		cmdSrc2							),
		.memReq(		memReq							),
		.memWe(			memWe							),
		.memAddr(		memAddr							),
		.memWData(		memWData						),
		.ldValid(		ldValid							),
		.ldData(		ldData							),
		.busy(			lsBusy							),
		.storeDone(		storeDone						),
		.res(			lsRes.unit						)
	);

	wbArbiter i_wbArbiter (
		.curIssueNo(	curIssueNo						),
		.aluRes(		aluRes.arb						),
		.lsRes(			lsRes.arb						),
		.wbValid(		wbValid							),
		.wbDst(			wbDst							),
		.wbIssueNo(		wbIssueNo						),
		.wbData(		wbData							)
	);

	// Both entries must never drain in one cycle over a single port
	wbOneTaken: assert property (@(posedge clock) disable iff (!rstN)
		!(aluRes.taken && lsRes.taken))
		else $error("Both results taken in the same cycle");

endmodule

// File: src/wbArbiter.sv
/*
	Write-back arbiter
	Sends the oldest pending result to the write-back port,
	age measured from the current issue number
*/

`timescale 1ns/1ps

module wbArbiter (
	input	execPkg::issueNoT	curIssueNo,		// Next issue number to go out
	execResultIf.arb			aluRes,
	execResultIf.arb			lsRes,
	output	logic				wbValid,
	output	execPkg::regIdxT	wbDst,
	output	execPkg::issueNoT	wbIssueNo,
	output	execPkg::dataT		wbData
);

	execPkg::issueNoT			aluAge;
	execPkg::issueNoT			lsAge;
	logic						lsOlder;
	logic						pickLs;
	logic						pickAlu;

	//////////////////////////////
	// Age of each entry
	//////////////////////////////

	// Modulo subtraction keeps the order across the wrap
	assign aluAge		= curIssueNo - aluRes.issueNo;
	assign lsAge		= curIssueNo - lsRes.issueNo;
	assign lsOlder		= lsAge > aluAge;

	//////////////////////////////
	// Selection
	//////////////////////////////
	always_comb begin
		pickLs	= 1'b0;
		pickAlu	= 1'b0;
		if (lsRes.valid && aluRes.valid) begin
			pickLs	= lsOlder;
			pickAlu	= ~lsOlder;						// Loser waits one cycle
		end else if (lsRes.valid) begin
			pickLs	= 1'b1;
		end else if (aluRes.valid) begin
			pickAlu	= 1'b1;
		end
	end

	assign lsRes.taken	= pickLs;
	assign aluRes.taken	= pickAlu;

	//////////////////////////////
	// Write-back port
	//////////////////////////////
	assign wbValid		= aluRes.valid | lsRes.valid;
	assign wbDst		= pickLs ? lsRes.dst		: aluRes.dst;
	assign wbIssueNo	= pickLs ? lsRes.issueNo	: aluRes.issueNo;
	assign wbData		= pickLs ? lsRes.data		: aluRes.data;

endmodule

// File: src/ldStUnit.sv
/*
	Load/store unit
	One outstanding memory access. A load waits for ldValid and
	keeps the word until write-back, a store only signals completion
*/

`timescale 1ns/1ps

module ldStUnit (
	input	logic				clock,
	input	logic				rstN,
	input	logic				start,			// Load/store command strobe
	input	logic				isStore,
	input	execPkg::regIdxT	dst,
	input	execPkg::issueNoT	issueNo,
	input	execPkg::addrT		addr,
	input	execPkg::dataT		stData,
	output	logic				memReq,			// One cycle request pulse
	output	logic				memWe,
	output	execPkg::addrT		memAddr,
	output	execPkg::dataT		memWData,
	input	logic				ldValid,		// Load data returned
	input	execPkg::dataT		ldData,
	output	logic				busy,
	output	logic				storeDone,
	execResultIf.unit			res
);

	execPkg::ldStStateT			state;
	execPkg::ldStStateT			nextState;

	execPkg::regIdxT			ldDst;
	execPkg::issueNoT			ldIssueNo;
	execPkg::dataT				ldWord;

	//////////////////////////////
	// State machine
	//////////////////////////////
	always_comb begin
		nextState = state;
		case (state)
			execPkg::lsIdle: begin
				if (start && !isStore) begin
					nextState = execPkg::lsWaitLoad;	// Stores never leave idle
				end
			end
			execPkg::lsWaitLoad: begin
				if (ldValid) begin
					nextState = execPkg::lsHold;
				end
			end
			execPkg::lsHold: begin
				if (res.taken) begin
					nextState = execPkg::lsIdle;
				end
			end
			default: nextState = execPkg::lsIdle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state		<= execPkg::lsIdle;
			memReq		<= 1'b0;
			memWe		<= 1'b0;
			storeDone	<= 1'b0;
		end else begin
			state		<= nextState;
			memReq		<= start;						// Cycle after the command
			memWe		<= start & isStore;
			storeDone	<= start & isStore;				// Same cycle as the write
		end
	end

	//////////////////////////////
	// Access and result payload
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (start) begin
			memAddr		<= addr;
			memWData	<= stData;
		end
		if (start && !isStore) begin
			ldDst		<= dst;
			ldIssueNo	<= issueNo;
		end
		if (state == execPkg::lsWaitLoad && ldValid) begin
			ldWord		<= ldData;
		end
	end

	assign busy			= (state != execPkg::lsIdle);	// Request until taken
	assign res.valid	= (state == execPkg::lsHold);
	assign res.dst		= ldDst;
	assign res.issueNo	= ldIssueNo;
	assign res.data		= ldWord;

	// The issue stage must watch busy
	lsNoStartBusy: assert property (@(posedge clock) disable iff (!rstN)
		start |-> !busy)
		else $error("Load/store command while the unit is busy");

	// Memory answers only an open load
	lsLdValidWait: assert property (@(posedge clock) disable iff (!rstN)
		ldValid |-> state == execPkg::lsWaitLoad)
		else $error("ldValid without an outstanding load");

endmodule

// File: src/aluUnit.sv
/*
	ALU pipeline
	Stage 1 registers the command, stage 2 computes and holds
	the result until the write-back arbiter takes it
*/

`timescale 1ns/1ps

module aluUnit #(
	parameter int DataWidth = 16
)(
	input	logic				clock,
	input	logic				rstN,
	input	logic				start,			// ALU command strobe
	input	execPkg::aluOpT		op,
	input	execPkg::regIdxT	dst,
	input	execPkg::issueNoT	issueNo,
	input	execPkg::dataT		src1,
	input	execPkg::dataT		src2,
	execResultIf.unit			res
);

	localparam int ShW = $clog2(DataWidth);

	logic						s1Valid;
	execPkg::aluOpT				s1Op;
	execPkg::regIdxT			s1Dst;
	execPkg::issueNoT			s1IssueNo;
	execPkg::dataT				s1Src1;
	execPkg::dataT				s1Src2;

	logic						outValid;
	execPkg::regIdxT			outDst;
	execPkg::issueNoT			outIssueNo;
	execPkg::dataT				outData;

	logic						advance;
	logic [ShW-1:0]				shAmt;
	logic [2*DataWidth-1:0]		prod;
	execPkg::dataT				aluResult;

	assign advance		= ~outValid | res.taken;	// Output entry free next edge
	assign shAmt		= s1Src2[ShW-1:0];
	assign prod			= (2*DataWidth)'(s1Src1) * (2*DataWidth)'(s1Src2);

	//////////////////////////////
	// Stage 1
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
		end else if (start) begin
			s1Valid <= 1'b1;
		end else if (advance) begin
			s1Valid <= 1'b0;						// Moved into the output entry
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			s1Op		<= op;
			s1Dst		<= dst;
			s1IssueNo	<= issueNo;
			s1Src1		<= src1;
			s1Src2		<= src2;
		end
	end

	//////////////////////////////
	// Stage 2
	//////////////////////////////
	always_comb begin
		case (s1Op)
			execPkg::aluAdd:	aluResult = s1Src1 + s1Src2;
			execPkg::aluSub:	aluResult = s1Src1 - s1Src2;
			execPkg::aluAnd:	aluResult = s1Src1 & s1Src2;
			execPkg::aluOr:		aluResult = s1Src1 | s1Src2;
			execPkg::aluXor:	aluResult = s1Src1 ^ s1Src2;
			execPkg::aluShl:	aluResult = s1Src1 << shAmt;
			execPkg::aluMul:	aluResult = prod[DataWidth-1:0];	// Low half only
			default:			aluResult = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= s1Valid;
		end
	end

	always_ff @(posedge clock) begin
		if (advance && s1Valid) begin
			outDst		<= s1Dst;
			outIssueNo	<= s1IssueNo;
			outData		<= aluResult;
		end
	end

	assign res.valid	= outValid;
	assign res.dst		= outDst;
	assign res.issueNo	= outIssueNo;
	assign res.data		= outData;

	// A third command with the output stuck would overwrite stage 1
	aluNoOverflow: assert property (@(posedge clock) disable iff (!rstN)
		start |-> !(s1Valid && outValid && !res.taken))
		else $error("ALU command while both stages are full");

endmodule

// File: src/execResultIf.sv
/*
	Pending result entry
	One unit offers a finished result, the arbiter answers with taken
*/

`timescale 1ns/1ps

interface execResultIf;

	logic				valid;				// Entry holds a result
	execPkg::regIdxT	dst;				// Destination register
	execPkg::issueNoT	issueNo;			// Issue number of the command
	execPkg::dataT		data;				// Result word
	logic				taken;				// Arbiter sends it this cycle

	// Producer side
	modport unit (
		output	valid,
		output	dst,
		output	issueNo,
		output	data,
		input	taken
	);

	// Arbiter side
	modport arb (
		input	valid,
		input	dst,
		input	issueNo,
		input	data,
		output	taken
	);

endinterface

// File: src/execPkg.sv
/*
	Execution stage definitions
	Word types, issue numbers, register indices and opcodes
	shared by the ALU, the load/store unit and the write-back arbiter
*/

package execPkg;

	//////////////////////////////
	// Command field widths
	//////////////////////////////
	localparam int DataW		= 16;				// Operand and result word
	localparam int IssueNoW		= 4;				// Wraps after 15
	localparam int RegIdxW		= 5;				// 32 destination registers
	localparam int AddrW		= 12;				// Memory word address
	localparam int OpW			= 3;				// Opcode field of a command

	//////////////////////////////
	// Word types
	//////////////////////////////
	typedef logic [DataW-1:0]		dataT;
	typedef logic [IssueNoW-1:0]	issueNoT;
	typedef logic [RegIdxW-1:0]		regIdxT;
	typedef logic [AddrW-1:0]		addrT;

	// Which unit a command goes to
	typedef enum logic {
		opAlu		= 1'b0,
		opLdSt		= 1'b1
	} opTypeT;

	// ALU operations with the low product half kept for multiply
	typedef enum logic [OpW-1:0] {
		aluAdd		= 3'd0,
		aluSub		= 3'd1,
		aluAnd		= 3'd2,
		aluOr		= 3'd3,
		aluXor		= 3'd4,
		aluShl		= 3'd5,
		aluMul		= 3'd6
	} aluOpT;

	// Load/store sequencing
	typedef enum logic [1:0] {
		lsIdle		= 2'd0,				// Free for a new access
		lsWaitLoad	= 2'd1,				// Request sent and data not back yet
		lsHold		= 2'd2				// Loaded word waits for write-back
	} ldStStateT;

endpackage
